// ==== Makefile ====
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert
TOP        ?= tb_rcc_vsw
RTL_TOP    ?= rcc_vsw_top
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^\*\* PASS \*\*$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
verilog/rcc_vsw_pkg.sv
verilog/rcc_reg_access.sv
verilog/rcc_vsw_reg.sv
verilog/lse_monitor.sv
verilog/rtc_clk_select.sv
verilog/rcc_vsw_top.sv
test/tb_rcc_vsw.sv

// ==== test/tb_rcc_vsw.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rcc_vsw;

  localparam int lse_startup  = 8;
  localparam int css_timeout  = 64;
  localparam int hse_div      = 32;
  // window lengths in clk cycles
  localparam int win_hse      = 1200;
  localparam int win_off      = 300;
  localparam int win_lsi      = 400;
  localparam int win_lse      = 400;
  localparam int rdy_poll_max = 100;
  // bypass needs one lse edge, far fewer reads than the crystal startup
  localparam int byp_poll_max = 12;
  localparam int irq_wait_max = 4 * css_timeout;
  // each status poll costs three cycles
  localparam int test_cycles  = win_hse + win_off + win_lsi + win_lse
                                + 3 * 3 * rdy_poll_max + 2 * irq_wait_max + 1500;
  localparam logic [rcc_vsw_pkg::bus_addr_w-1:0] bdcr = rcc_vsw_pkg::bdcr_addr;

  logic                               clk;
  logic                               reset;
  logic                               bus_wr;
  logic                               bus_rd;
  logic [rcc_vsw_pkg::bus_addr_w-1:0] bus_addr;
  logic [31:0]                        bus_wdata;
  logic [3:0]                         bus_be;
  logic [31:0]                        bus_rdata;
  logic                               lse_clk;
  logic                               lsi_tick;
  logic                               hse_tick;
  logic                               lseon;
  logic                               lsebyp;
  logic [1:0]                         lsedrv;
  logic                               lsecss_irq;
  logic                               rtc_tick;

  // bdcr reference model
  logic                  m_lseon;
  logic                  m_lserdy;
  logic                  m_lsebyp;
  logic [1:0]            m_lsedrv;
  logic                  m_lsecsson;
  logic                  m_lsecssd;
  rcc_vsw_pkg::rtc_src_e m_rtcsel;
  logic                  sel_locked;
  logic                  m_rtcen;
  logic                  m_bdrst;

  integer seed = 32'h87739d48;
  int     errors;
  int     checks;
  int     irq_count;
  int     lsi_count;
  int     hse_count;
  int     lse_count;
  int     tick_count;
  int     lse_div;
  logic   lse_run;
  logic   src_win;
  logic   tick_win_d1;
  logic   tick_win;

  rcc_vsw_top #(
    .lse_startup (lse_startup),
    .css_timeout (css_timeout),
    .hse_div     (hse_div)
  ) i_rcc_vsw_top (
    .clk        (clk),
    .reset      (reset),
    .bus_wr     (bus_wr),
    .bus_rd     (bus_rd),
    .bus_addr   (bus_addr),
    .bus_wdata  (bus_wdata),
    .bus_be     (bus_be),
    .bus_rdata  (bus_rdata),
    .lse_clk    (lse_clk),
    .lsi_tick   (lsi_tick),
    .hse_tick   (hse_tick),
    .lseon      (lseon),
    .lsebyp     (lsebyp),
    .lsedrv     (lsedrv),
    .lsecss_irq (lsecss_irq),
    .rtc_tick   (rtc_tick)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ------------------------------------------------------------------------
  // oscillator models and counters
  // ------------------------------------------------------------------------
  // lse level flips every 5 clk cycles while running
  always @(posedge clk) begin
    if (lse_run) begin
      if (lse_div == 4) begin
        lse_div = 0;
        if (src_win && !lse_clk) lse_count++;
        lse_clk <= ~lse_clk;
      end else begin
        lse_div = lse_div + 1;
      end
    end
  end

  // sparse lsi and dense hse strobes
  always @(posedge clk) begin
    lsi_tick <= (($random(seed) & 7) == 0);
    hse_tick <= (($random(seed) & 1) == 1);
  end

  // tick window trails the source window by the 2-cycle latency
  always @(posedge clk) begin
    tick_win_d1 <= src_win;
    tick_win    <= tick_win_d1;
    if (src_win && lsi_tick) lsi_count++;
    if (src_win && hse_tick) hse_count++;
    if (tick_win && rtc_tick) tick_count++;
    if (lsecss_irq) irq_count++;
  end

  // ------------------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------------------
  function automatic logic [31:0] model_word();
    logic [31:0] w;
    w       = 32'h0;
    w[0]    = m_lseon;
    w[1]    = m_lserdy;
    w[2]    = m_lsebyp;
    w[4:3]  = m_lsedrv;
    w[5]    = m_lsecsson;
    w[6]    = m_lsecssd;
    w[9:8]  = m_rtcsel;
    w[15]   = m_rtcen;
    w[16]   = m_bdrst;
    return w;
  endfunction

  function automatic void model_write(input logic [31:0] wdata, input logic [3:0] be);
    logic domain_clr;
    // the edge that sets bdrst already clears the domain
    domain_clr = m_bdrst | (be[2] & wdata[16]);
    if (be[2]) m_bdrst = wdata[16];
    if (domain_clr) begin
      m_lseon    = 1'b0;
      m_lsebyp   = 1'b0;
      m_lsedrv   = 2'b00;
      m_lsecsson = 1'b0;
      m_lsecssd  = 1'b0;
      m_rtcsel   = rcc_vsw_pkg::rtc_src_none;
      sel_locked = 1'b0;
      m_rtcen    = 1'b0;
    end else begin
      if (be[0]) begin
        m_lseon  = wdata[0];
        m_lsebyp = wdata[2];
        m_lsedrv = wdata[4:3];
        // set only
        if (wdata[5]) m_lsecsson = 1'b1;
      end
      if (be[1]) begin
        m_rtcen = wdata[15];
        if (!sel_locked) begin
          m_rtcsel   = rcc_vsw_pkg::rtc_src_e'(wdata[9:8]);
          sel_locked = (wdata[9:8] != 2'b00);
        end
      end
    end
    if (!m_lseon) m_lserdy = 1'b0;
  endfunction

  // ------------------------------------------------------------------------
  // bus tasks and checks
  // ------------------------------------------------------------------------
  task automatic bus_write(input logic [7:0] addr, input logic [31:0] wdata,
                           input logic [3:0] be);
    @(posedge clk);
    bus_wr    <= 1'b1;
    bus_addr  <= addr;
    bus_wdata <= wdata;
    bus_be    <= be;
    @(posedge clk);
    bus_wr <= 1'b0;
    if (addr == bdcr) model_write(wdata, be);
  endtask

  task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge clk);
    bus_rd   <= 1'b1;
    bus_addr <= addr;
    @(posedge clk);
    bus_rd <= 1'b0;
    // rdata settled by the falling edge
    @(negedge clk);
    data = bus_rdata;
  endtask

  task automatic read_check(input logic [7:0] addr, input string what);
    logic [31:0] data;
    logic [31:0] exp;
    bus_read(addr, data);
    exp = (addr == bdcr) ? model_word() : 32'h0;
    checks++;
    assert (data === exp) else begin
      errors++;
      $display("Error at %0t: %s, read %h expected %h", $time, what, data, exp);
    end
    checks++;
    assert (lseon === m_lseon && lsebyp === m_lsebyp && lsedrv === m_lsedrv) else begin
      errors++;
      $display("Error at %0t: %s, pad controls %b %b %b", $time, what, lseon, lsebyp, lsedrv);
    end
  endtask

  task automatic wait_lserdy(input int max_polls);
    logic [31:0] data;
    int          tries;
    data  = 32'h0;
    tries = 0;
    while (data[1] !== 1'b1 && tries < max_polls) begin
      bus_read(bdcr, data);
      tries++;
    end
    if (data[1] !== 1'b1) begin
      errors++;
      $display("lserdy never came up within %0d status reads", tries);
    end
    m_lserdy = 1'b1;
  endtask

  task automatic run_window(input int cycles);
    @(posedge clk);
    lsi_count  = 0;
    hse_count  = 0;
    lse_count  = 0;
    tick_count = 0;
    src_win <= 1'b1;
    repeat (cycles) @(posedge clk);
    src_win <= 1'b0;
    repeat (4) @(posedge clk);
  endtask

  task automatic check_count(input string what, input int got, input int exp, input int tol);
    checks++;
    assert (got >= exp - tol && got <= exp + tol) else begin
      errors++;
      $display("Error at %0t: %s, %0d rtc ticks expected %0d", $time, what, got, exp);
    end
  endtask

  // ------------------------------------------------------------------------
  // watchdog
  // ------------------------------------------------------------------------
  initial begin
    repeat (test_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the test sequence stalled", test_cycles);
    $display("** FAIL **");
    $finish;
  end

  // ------------------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------------------
  initial begin
    reset       = 1'b1;
    bus_wr      = 1'b0;
    bus_rd      = 1'b0;
    bus_addr    = '0;
    bus_wdata   = 32'h0;
    bus_be      = 4'h0;
    lse_clk     = 1'b0;
    lsi_tick    = 1'b0;
    hse_tick    = 1'b0;
    lse_run     = 1'b0;
    src_win     = 1'b0;
    tick_win_d1 = 1'b0;
    tick_win    = 1'b0;
    lse_div     = 0;
    errors      = 0;
    checks      = 0;
    irq_count   = 0;
    m_lseon     = 1'b0;
    m_lserdy    = 1'b0;
    m_lsebyp    = 1'b0;
    m_lsedrv    = 2'b00;
    m_lsecsson  = 1'b0;
    m_lsecssd   = 1'b0;
    m_rtcsel    = rcc_vsw_pkg::rtc_src_none;
    sel_locked  = 1'b0;
    m_rtcen     = 1'b0;
    m_bdrst     = 1'b0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    // reset value and plain fields
    read_check(bdcr, "after reset");
    bus_write(bdcr, 32'h0000_801d, 4'b0001);
    read_check(bdcr, "byte 0 only");
    bus_write(bdcr, 32'h0000_8018, 4'b0010);
    read_check(bdcr, "byte 1 only");
    bus_write(bdcr, 32'hffff_ff9a, 4'b1000);
    read_check(bdcr, "byte 3 only");
    bus_write(bdcr, 32'h0000_0042, 4'b0011);
    read_check(bdcr, "read-only bits written");
    bus_write(8'h00, 32'h0000_ffff, 4'b1111);
    read_check(bdcr, "write to other address");
    read_check(8'h00, "read of other address");
    bus_write(bdcr, 32'h0000_000c, 4'b0001);
    read_check(bdcr, "lsebyp and lsedrv");

    // lse ready with a crystal and in bypass
    lse_run <= 1'b1;
    bus_write(bdcr, 32'h0000_0001, 4'b0001);
    wait_lserdy(rdy_poll_max);
    read_check(bdcr, "lse ready");
    bus_write(bdcr, 32'h0000_0000, 4'b0001);
    read_check(bdcr, "lse off");
    bus_write(bdcr, 32'h0000_0005, 4'b0001);
    wait_lserdy(byp_poll_max);
    read_check(bdcr, "lse bypass ready");

    // rtcsel write once
    bus_write(bdcr, 32'h0000_0000, 4'b0010);
    read_check(bdcr, "rtcsel zero");
    bus_write(bdcr, 32'h0000_0100, 4'b0010);
    read_check(bdcr, "rtcsel first write");
    bus_write(bdcr, 32'h0000_0300, 4'b0010);
    read_check(bdcr, "rtcsel locked");

    // clock security
    bus_write(bdcr, 32'h0000_0025, 4'b0001);
    read_check(bdcr, "css on");
    bus_write(bdcr, 32'h0000_0005, 4'b0001);
    read_check(bdcr, "css clear attempt");
    lse_run <= 1'b0;
    begin : wait_irq
      int waited;
      waited = 0;
      while (irq_count == 0 && waited < irq_wait_max) begin
        @(negedge clk);
        waited++;
      end
      if (irq_count == 0) begin
        errors++;
        $display("no lsecss_irq pulse within %0d cycles of stopping the LSE", waited);
      end
    end
    repeat (3 * css_timeout) @(posedge clk);
    checks++;
    assert (irq_count == 1) else begin
      errors++;
      $display("Error at %0t: %0d lsecss_irq pulses, expected one", $time, irq_count);
    end
    m_lsecssd  = 1'b1;
    m_lsecsson = 1'b0;
    m_lserdy   = 1'b0;
    sel_locked = 1'b0;
    read_check(bdcr, "after lse failure");
    bus_write(bdcr, 32'h0000_0200, 4'b0010);
    read_check(bdcr, "rtcsel after failure");

    // backup-domain reset
    bus_write(bdcr, 32'h0001_0000, 4'b0100);
    read_check(bdcr, "bdrst set");
    bus_write(bdcr, 32'h0000_0001, 4'b0001);
    read_check(bdcr, "write during bdrst");
    bus_write(bdcr, 32'h0000_0000, 4'b0100);
    read_check(bdcr, "bdrst clear");
    bus_write(bdcr, 32'h0000_0300, 4'b0010);
    read_check(bdcr, "rtcsel after bdrst");

    // rtc ticks per source and with rtcen off
    bus_write(bdcr, 32'h0000_8300, 4'b0010);
    run_window(win_hse);
    check_count("hse source", tick_count, hse_count / hse_div, 1);
    bus_write(bdcr, 32'h0000_0300, 4'b0010);
    run_window(win_off);
    check_count("rtcen off", tick_count, 0, 0);
    bus_write(bdcr, 32'h0001_0000, 4'b0100);
    bus_write(bdcr, 32'h0000_0000, 4'b0100);
    bus_write(bdcr, 32'h0000_8200, 4'b0010);
    read_check(bdcr, "lsi selected");
    run_window(win_lsi);
    check_count("lsi source", tick_count, lsi_count, 2);
    bus_write(bdcr, 32'h0001_0000, 4'b0100);
    bus_write(bdcr, 32'h0000_0000, 4'b0100);
    lse_run <= 1'b1;
    bus_write(bdcr, 32'h0000_0001, 4'b0001);
    wait_lserdy(rdy_poll_max);
    bus_write(bdcr, 32'h0000_8100, 4'b0010);
    read_check(bdcr, "lse selected");
    run_window(win_lse);
    check_count("lse source", tick_count, lse_count, 2);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/lse_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module lse_monitor #(
  parameter int lse_startup = 8,
  parameter int css_timeout = 64
) (
  input  logic clk,
  input  logic reset,
  input  logic lse_clk,
  input  logic lseon,
  input  logic lsebyp,
  input  logic lsecsson,
  output logic lse_rdy,
  output logic lse_edge,
  output logic lsecss_fail
);

  localparam int start_w = $clog2(lse_startup + 1);
  localparam int idle_w  = $clog2(css_timeout + 1);

  logic               lse_sync1;
  logic               lse_sync2;
  logic               lse_prev;
  logic [start_w-1:0] start_cnt;
  logic [idle_w-1:0]  idle_cnt;
  logic               css_armed;

  // --------------------------------------------------------------------------
  // lse level into the clk domain
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      lse_sync1 <= 1'b0;
      lse_sync2 <= 1'b0;
      lse_prev  <= 1'b0;
    end else begin
      lse_sync1 <= lse_clk;
      lse_sync2 <= lse_sync1;
      lse_prev  <= lse_sync2;
    end
  end

  // rising edge of the synced level
  assign lse_edge = lse_sync2 & ~lse_prev;

  // --------------------------------------------------------------------------
  // startup count
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset || !lseon || lsecss_fail) begin
      start_cnt <= '0;
      lse_rdy   <= 1'b0;
    end else if (lse_edge && !lse_rdy) begin
      // bypass needs just one edge
      if (lsebyp || start_cnt == start_w'(lse_startup - 1)) begin
        lse_rdy <= 1'b1;
      end else begin
        start_cnt <= start_cnt + 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // clock security
  // --------------------------------------------------------------------------
  assign css_armed = lsecsson & lse_rdy;

  // cycles since last edge, saturates at the timeout
  always_ff @(posedge clk) begin
    if (reset || !css_armed || lse_edge || lsecss_fail) begin
      idle_cnt <= '0;
    end else if (idle_cnt != idle_w'(css_timeout)) begin
      idle_cnt <= idle_cnt + 1'b1;
    end
  end

  // single pulse, the cycle after timeout is reached
  always_ff @(posedge clk) begin
    if (reset) begin
      lsecss_fail <= 1'b0;
    end else begin
      lsecss_fail <= css_armed && !lsecss_fail && (idle_cnt == idle_w'(css_timeout));
    end
  end

endmodule

`default_nettype wire

// ==== verilog/rcc_reg_access.sv ====
`timescale 1ns/1ps
`default_nettype none

module rcc_reg_access (
  input  logic                                clk,
  input  logic                                reset,
  // register bus
  input  logic                                bus_wr,
  input  logic                                bus_rd,
  input  logic [rcc_vsw_pkg::bus_addr_w-1:0]  bus_addr,
  input  logic [31:0]                         bus_wdata,
  input  logic [3:0]                          bus_be,
  output logic [31:0]                         bus_rdata,
  // current field values for read back
  input  logic                                cur_bdrst,
  input  logic                                cur_rtcen,
  input  rcc_vsw_pkg::rtc_src_e               cur_rtcsel,
  input  logic                                cur_lserdy,
  input  logic                                cur_lsecssd,
  input  logic                                cur_lsecsson,
  input  logic [1:0]                          cur_lsedrv,
  input  logic                                cur_lsebyp,
  input  logic                                cur_lseon,
  // byte write enables
  output logic                                byte0_wren,
  output logic                                byte1_wren,
  output logic                                byte2_wren,
  // next field values
  output logic                                nxt_bdrst,
  output logic                                nxt_rtcen,
  output rcc_vsw_pkg::rtc_src_e               nxt_rtcsel,
  output logic                                nxt_lsecsson,
  output logic [1:0]                          nxt_lsedrv,
  output logic                                nxt_lsebyp,
  output logic                                nxt_lseon
);

  logic        addr_hit;
  logic [31:0] rd_word;

  // --------------------------------------------------------------------------
  // write decode
  // --------------------------------------------------------------------------
  assign addr_hit = (bus_addr == rcc_vsw_pkg::bdcr_addr);

  // byte 3 holds no fields, so bus_be[3] has no strobe
  assign byte0_wren = bus_wr & addr_hit & bus_be[0];
  assign byte1_wren = bus_wr & addr_hit & bus_be[1];
  assign byte2_wren = bus_wr & addr_hit & bus_be[2];

  // field slices, lserdy and lsecssd bits are dropped
  assign nxt_lseon    = bus_wdata[rcc_vsw_pkg::lseon_pos];
  assign nxt_lsebyp   = bus_wdata[rcc_vsw_pkg::lsebyp_pos];
  assign nxt_lsedrv   = bus_wdata[rcc_vsw_pkg::lsedrv_msb:rcc_vsw_pkg::lsedrv_lsb];
  assign nxt_lsecsson = bus_wdata[rcc_vsw_pkg::lsecsson_pos];
  assign nxt_rtcsel   = rcc_vsw_pkg::rtc_src_e'(
                          bus_wdata[rcc_vsw_pkg::rtcsel_msb:rcc_vsw_pkg::rtcsel_lsb]);
  assign nxt_rtcen    = bus_wdata[rcc_vsw_pkg::rtcen_pos];
  assign nxt_bdrst    = bus_wdata[rcc_vsw_pkg::bdrst_pos];

  // --------------------------------------------------------------------------
  // read path
  // --------------------------------------------------------------------------
  // pack bdcr, unused bits stay zero
  always_comb begin
    rd_word = '0;
    rd_word[rcc_vsw_pkg::lseon_pos]    = cur_lseon;
    rd_word[rcc_vsw_pkg::lserdy_pos]   = cur_lserdy;
    rd_word[rcc_vsw_pkg::lsebyp_pos]   = cur_lsebyp;
    rd_word[rcc_vsw_pkg::lsedrv_msb:rcc_vsw_pkg::lsedrv_lsb] = cur_lsedrv;
    rd_word[rcc_vsw_pkg::lsecsson_pos] = cur_lsecsson;
    rd_word[rcc_vsw_pkg::lsecssd_pos]  = cur_lsecssd;
    rd_word[rcc_vsw_pkg::rtcsel_msb:rcc_vsw_pkg::rtcsel_lsb] = cur_rtcsel;
    rd_word[rcc_vsw_pkg::rtcen_pos]    = cur_rtcen;
    rd_word[rcc_vsw_pkg::bdrst_pos]    = cur_bdrst;
  end

  // data valid the cycle after the strobe, held until next read
  always_ff @(posedge clk) begin
    if (reset) begin
      bus_rdata <= '0;
    end else if (bus_rd) begin
      bus_rdata <= addr_hit ? rd_word : 32'h0;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/rcc_vsw_pkg.sv ====
`default_nettype none

package rcc_vsw_pkg;

  // --------------------------------------------------------------------------
  // register bus
  // --------------------------------------------------------------------------
  localparam int bus_addr_w = 8;

  // word address of the backup-domain control register
  localparam logic [bus_addr_w-1:0] bdcr_addr = 8'h1c;

  // --------------------------------------------------------------------------
  // bdcr field positions
  // --------------------------------------------------------------------------
  // byte 0, lse control and css
  localparam int lseon_pos    = 0;
  localparam int lserdy_pos   = 1;
  localparam int lsebyp_pos   = 2;
  localparam int lsedrv_lsb   = 3;
  localparam int lsedrv_msb   = 4;
  localparam int lsecsson_pos = 5;
  localparam int lsecssd_pos  = 6;

  // byte 1, rtc clock
  localparam int rtcsel_lsb   = 8;
  localparam int rtcsel_msb   = 9;
  localparam int rtcen_pos    = 15;

  // byte 2, backup-domain reset
  localparam int bdrst_pos    = 16;

  // rtc clock source encoding
  typedef enum logic [1:0] {
    rtc_src_none = 2'b00,
    rtc_src_lse  = 2'b01,
    rtc_src_lsi  = 2'b10,
    rtc_src_hse  = 2'b11
  } rtc_src_e;

endpackage

`default_nettype wire

// ==== verilog/rcc_vsw_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module rcc_vsw_reg (
  input  logic                   clk,
  input  logic                   reset,
  // write side
  input  logic                   byte0_wren,
  input  logic                   byte1_wren,
  input  logic                   byte2_wren,
  input  logic                   nxt_bdrst,
  input  logic                   nxt_rtcen,
  input  rcc_vsw_pkg::rtc_src_e  nxt_rtcsel,
  input  logic                   nxt_lsecsson,
  input  logic [1:0]             nxt_lsedrv,
  input  logic                   nxt_lsebyp,
  input  logic                   nxt_lseon,
  // status from the lse monitor
  input  logic                   lse_rdy,
  input  logic                   lsecss_fail,
  // stored fields
  output logic                   cur_bdrst,
  output logic                   cur_rtcen,
  output rcc_vsw_pkg::rtc_src_e  cur_rtcsel,
  output logic                   cur_lserdy,
  output logic                   cur_lsecssd,
  output logic                   cur_lsecsson,
  output logic [1:0]             cur_lsedrv,
  output logic                   cur_lsebyp,
  output logic                   cur_lseon
);

  // rtcsel already written with a nonzero source
  logic rtcsel_lock;
  // backup domain held in reset, also on the edge that sets bdrst
  logic bd_clr;

  assign bd_clr = cur_bdrst | (byte2_wren & nxt_bdrst);

  // --------------------------------------------------------------------------
  // bdrst, byte 2, plain rw
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      cur_bdrst <= 1'b0;
    end else if (byte2_wren) begin
      cur_bdrst <= nxt_bdrst;
    end
  end

  // --------------------------------------------------------------------------
  // byte 0, lse control
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset || bd_clr) begin
      cur_lseon    <= 1'b0;
      cur_lsebyp   <= 1'b0;
      cur_lsedrv   <= 2'b00;
      cur_lsecsson <= 1'b0;
    end else begin
      if (byte0_wren) begin
        cur_lseon  <= nxt_lseon;
        cur_lsebyp <= nxt_lsebyp;
        cur_lsedrv <= nxt_lsedrv;
      end
      // set only by software, a failure clears it
      if (lsecss_fail) begin
        cur_lsecsson <= 1'b0;
      end else if (byte0_wren && nxt_lsecsson) begin
        cur_lsecsson <= 1'b1;
      end
    end
  end

  // sticky failure flag, gone only with reset or bdrst
  always_ff @(posedge clk) begin
    if (reset || bd_clr) begin
      cur_lsecssd <= 1'b0;
    end else if (lsecss_fail) begin
      cur_lsecssd <= 1'b1;
    end
  end

  // ready only counts while the oscillator is on
  assign cur_lserdy = lse_rdy & cur_lseon;

  // --------------------------------------------------------------------------
  // byte 1, rtc clock
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset || bd_clr) begin
      cur_rtcen <= 1'b0;
    end else if (byte1_wren) begin
      cur_rtcen <= nxt_rtcen;
    end
  end

  // write once, a zero write keeps it open
  // failure unlocks so software can move off the dead lse
  always_ff @(posedge clk) begin
    if (reset || bd_clr) begin
      cur_rtcsel  <= rcc_vsw_pkg::rtc_src_none;
      rtcsel_lock <= 1'b0;
    end else if (lsecss_fail) begin
      rtcsel_lock <= 1'b0;
    end else if (byte1_wren && !rtcsel_lock) begin
      cur_rtcsel  <= nxt_rtcsel;
      rtcsel_lock <= (nxt_rtcsel != rcc_vsw_pkg::rtc_src_none);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/rcc_vsw_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rcc_vsw_top #(
  parameter int lse_startup = 8,
  parameter int css_timeout = 64,
  parameter int hse_div     = 32
) (
  input  logic                               clk,
  input  logic                               reset,
  // register bus
  input  logic                               bus_wr,
  input  logic                               bus_rd,
  input  logic [rcc_vsw_pkg::bus_addr_w-1:0] bus_addr,
  input  logic [31:0]                        bus_wdata,
  input  logic [3:0]                         bus_be,
  output logic [31:0]                        bus_rdata,
  // oscillators
  input  logic                               lse_clk,
  input  logic                               lsi_tick,
  input  logic                               hse_tick,
  // lse pad controls
  output logic                               lseon,
  output logic                               lsebyp,
  output logic [1:0]                         lsedrv,
  output logic                               lsecss_irq,
  output logic                               rtc_tick
);

  logic                  byte0_wren;
  logic                  byte1_wren;
  logic                  byte2_wren;
  logic                  nxt_bdrst;
  logic                  nxt_rtcen;
  rcc_vsw_pkg::rtc_src_e nxt_rtcsel;
  logic                  nxt_lsecsson;
  logic [1:0]            nxt_lsedrv;
  logic                  nxt_lsebyp;
  logic                  nxt_lseon;
  logic                  cur_bdrst;
  logic                  cur_rtcen;
  rcc_vsw_pkg::rtc_src_e cur_rtcsel;
  logic                  cur_lserdy;
  logic                  cur_lsecssd;
  logic                  cur_lsecsson;
  logic                  lse_rdy;
  logic                  lse_edge;
  logic                  lsecss_fail;

  // failure pulse goes straight out as the interrupt
  assign lsecss_irq = lsecss_fail;

  // --------------------------------------------------------------------------
  // register access and storage
  // --------------------------------------------------------------------------
  rcc_reg_access i_rcc_reg_access (
    .clk          (clk),
    .reset        (reset),
    .bus_wr       (bus_wr),
    .bus_rd       (bus_rd),
    .bus_addr     (bus_addr),
    .bus_wdata    (bus_wdata),
    .bus_be       (bus_be),
    .bus_rdata    (bus_rdata),
    .cur_bdrst    (cur_bdrst),
    .cur_rtcen    (cur_rtcen),
    .cur_rtcsel   (cur_rtcsel),
    .cur_lserdy   (cur_lserdy),
    .cur_lsecssd  (cur_lsecssd),
    .cur_lsecsson (cur_lsecsson),
    .cur_lsedrv   (lsedrv),
    .cur_lsebyp   (lsebyp),
    .cur_lseon    (lseon),
    .byte0_wren   (byte0_wren),
    .byte1_wren   (byte1_wren),
    .byte2_wren   (byte2_wren),
    .nxt_bdrst    (nxt_bdrst),
    .nxt_rtcen    (nxt_rtcen),
    .nxt_rtcsel   (nxt_rtcsel),
    .nxt_lsecsson (nxt_lsecsson),
    .nxt_lsedrv   (nxt_lsedrv),
    .nxt_lsebyp   (nxt_lsebyp),
    .nxt_lseon    (nxt_lseon)
  );

  rcc_vsw_reg i_rcc_vsw_reg (
    .clk          (clk),
    .reset        (reset),
    .byte0_wren   (byte0_wren),
    .byte1_wren   (byte1_wren),
    .byte2_wren   (byte2_wren),
    .nxt_bdrst    (nxt_bdrst),
    .nxt_rtcen    (nxt_rtcen),
    .nxt_rtcsel   (nxt_rtcsel),
    .nxt_lsecsson (nxt_lsecsson),
    .nxt_lsedrv   (nxt_lsedrv),
    .nxt_lsebyp   (nxt_lsebyp),
    .nxt_lseon    (nxt_lseon),
    .lse_rdy      (lse_rdy),
    .lsecss_fail  (lsecss_fail),
    .cur_bdrst    (cur_bdrst),
    .cur_rtcen    (cur_rtcen),
    .cur_rtcsel   (cur_rtcsel),
    .cur_lserdy   (cur_lserdy),
    .cur_lsecssd  (cur_lsecssd),
    .cur_lsecsson (cur_lsecsson),
    .cur_lsedrv   (lsedrv),
    .cur_lsebyp   (lsebyp),
    .cur_lseon    (lseon)
  );

  // --------------------------------------------------------------------------
  // lse monitor and rtc clock
  // --------------------------------------------------------------------------
  lse_monitor #(
    .lse_startup (lse_startup),
    .css_timeout (css_timeout)
  ) i_lse_monitor (
    .clk         (clk),
    .reset       (reset),
    .lse_clk     (lse_clk),
    .lseon       (lseon),
    .lsebyp      (lsebyp),
    .lsecsson    (cur_lsecsson),
    .lse_rdy     (lse_rdy),
    .lse_edge    (lse_edge),
    .lsecss_fail (lsecss_fail)
  );

  rtc_clk_select #(
    .hse_div (hse_div)
  ) i_rtc_clk_select (
    .clk      (clk),
    .reset    (reset),
    .rtcsel   (cur_rtcsel),
    .rtcen    (cur_rtcen),
    .lse_rdy  (lse_rdy),
    .lse_edge (lse_edge),
    .lsi_tick (lsi_tick),
    .hse_tick (hse_tick),
    .rtc_tick (rtc_tick)
  );

endmodule

`default_nettype wire

// ==== verilog/rtc_clk_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module rtc_clk_select #(
  parameter int hse_div = 32
) (
  input  logic                  clk,
  input  logic                  reset,
  input  rcc_vsw_pkg::rtc_src_e rtcsel,
  input  logic                  rtcen,
  input  logic                  lse_rdy,
  input  logic                  lse_edge,
  input  logic                  lsi_tick,
  input  logic                  hse_tick,
  output logic                  rtc_tick
);

  localparam int div_w = (hse_div > 1) ? $clog2(hse_div) : 1;

  logic [div_w-1:0] hse_cnt;
  logic             hse_strobe;
  logic             src_strobe;
  logic             src_q;

  // --------------------------------------------------------------------------
  // hse prescaler
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      hse_cnt    <= '0;
      hse_strobe <= 1'b0;
    end else begin
      hse_strobe <= 1'b0;
      if (hse_tick) begin
        if (hse_cnt == div_w'(hse_div - 1)) begin
          hse_cnt    <= '0;
          hse_strobe <= 1'b1;
        end else begin
          hse_cnt <= hse_cnt + 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // source mux and gating
  // --------------------------------------------------------------------------
  always_comb begin
    unique case (rtcsel)
      rcc_vsw_pkg::rtc_src_lse: src_strobe = lse_edge & lse_rdy;
      rcc_vsw_pkg::rtc_src_lsi: src_strobe = lsi_tick;
      rcc_vsw_pkg::rtc_src_hse: src_strobe = hse_strobe;
      default:                  src_strobe = 1'b0;
    endcase
  end

  // two stages, source to tick
  always_ff @(posedge clk) begin
    if (reset) begin
      src_q    <= 1'b0;
      rtc_tick <= 1'b0;
    end else begin
      src_q    <= src_strobe & rtcen;
      rtc_tick <= src_q;
    end
  end

endmodule

`default_nettype wire
